/* vlog.f */
+incdir+.
step_pkg.sv
step_csr.sv
step_axis.sv
step_readback.sv
step_top.sv
tb_clock_gen.sv
tb_step_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the stepper controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_step_top -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

/* tb_step_top.sv */
`include "step_defs.svh"

module tb_step_top
  import step_pkg::*;
();

  typedef enum logic [3:0]
  {
    OP_WR, OP_RD, OP_RD_MON, OP_WAIT, OP_MARK,
    OP_PULSES, OP_BELOW, OP_EN, OP_DIR, OP_RST
  } op_e;

  typedef struct packed
  {
    op_e         op;
    logic [7:0]  addr; // axis field also picks the port bit
    logic [31:0] data;
    logic [31:0] exp;
  } entry_t;

  logic                      clk;
  logic                      rst;
  logic [7:0]                address;
  logic [31:0]               writedata;
  logic                      write;
  logic                      read;
  logic [31:0]               readdata;
  logic [`STEP_NUM_AXES-1:0] step;
  logic [`STEP_NUM_AXES-1:0] dir;
  logic [`STEP_NUM_AXES-1:0] enable;

  entry_t      tbl[$];
  int unsigned seed = 67;
  int unsigned wait_total = 0;
  int unsigned mon_cnt[`STEP_NUM_AXES] = '{default: 0};
  int unsigned mark[`STEP_NUM_AXES];
  logic [31:0] sh_period[`STEP_NUM_AXES];
  logic [31:0] sh_pulses[`STEP_NUM_AXES];
  logic        sh_dir[`STEP_NUM_AXES];
  bit          table_ready = 1'b0;

  tb_clock_gen #(.PERIOD(20)) clock_gen_inst (.clk(clk));

  step_top step_top_inst
  (
    .clk       (clk),
    .rst       (rst),
    .address   (address),
    .writedata (writedata),
    .write     (write),
    .read      (read),
    .readdata  (readdata),
    .step      (step),
    .dir       (dir),
    .enable    (enable)
  );

  // step pulses last one cycle, so high cycles count steps
  always @(negedge clk)
  begin
    if (!rst)
    begin
      for (int i = 0; i < `STEP_NUM_AXES; i++)
      begin
        if (step[i])
          mon_cnt[i] = mon_cnt[i] + 1;
      end
    end
  end

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("Error at time %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    seed = seed * 32'd1103515245 + 32'd12345;
    return ((seed >> 16) & 32'h7fff) % n;
  endfunction

  function automatic logic [7:0] reg_addr(input int a, input logic [3:0] off);
    return {4'(a), off};
  endfunction

  function automatic void add_entry(input op_e op, input logic [7:0] addr,
                                    input logic [31:0] data, input logic [31:0] exp);
    entry_t e;
    e.op   = op;
    e.addr = addr;
    e.data = data;
    e.exp  = exp;
    tbl.push_back(e);
    if (op == OP_WAIT || op == OP_RST)
      wait_total += data;
  endfunction

  function automatic void add_read(input logic [7:0] addr, input logic [31:0] exp);
    add_entry(OP_RD, addr, 32'd0, exp);
  endfunction

  // shadow copy follows every write that lands in the map
  function automatic void add_write(input int a, input logic [3:0] off, input logic [31:0] data);
    add_entry(OP_WR, reg_addr(a, off), data, 32'd0);
    if (a < `STEP_NUM_AXES)
    begin
      case (off)
        `STEP_REG_PERIOD: sh_period[a] = data;
        `STEP_REG_PULSES: sh_pulses[a] = data;
        `STEP_REG_DIR:    sh_dir[a] = data[0];
        default: ;
      endcase
    end
  endfunction

  // config is all zero out of reset
  function automatic void clear_shadows();
    for (int a = 0; a < `STEP_NUM_AXES; a++)
    begin
      sh_period[a] = '0;
      sh_pulses[a] = '0;
      sh_dir[a]    = 1'b0;
    end
  endfunction

  function automatic void add_cfg_reads(input int a);
    add_read(reg_addr(a, `STEP_REG_PERIOD), sh_period[a]);
    add_read(reg_addr(a, `STEP_REG_PULSES), sh_pulses[a]);
    add_read(reg_addr(a, `STEP_REG_DIR), 32'(sh_dir[a]));
  endfunction

  function automatic void build_table();
    int unsigned p;
    int unsigned n;
    int unsigned w;
    int          last;
    last = `STEP_NUM_AXES - 1;
    clear_shadows();
    for (int a = 0; a < `STEP_NUM_AXES; a++)
      mark[a] = 0;

    // reset state, outputs quiet
    add_entry(OP_WAIT, 8'h00, 32'd5, 32'd0);
    for (int a = 0; a < `STEP_NUM_AXES; a++)
    begin
      add_read(reg_addr(a, `STEP_REG_CTRL), 32'd0);
      add_read(reg_addr(a, `STEP_REG_STATE), 32'(ST_IDLE));
      add_read(reg_addr(a, `STEP_REG_COUNT), 32'd0);
      add_cfg_reads(a);
      add_entry(OP_EN, reg_addr(a, 4'd0), 32'd0, 32'd0);
      add_entry(OP_PULSES, reg_addr(a, 4'd0), 32'd0, 32'd0);
    end
    add_read({`STEP_ERR_AXIS, `STEP_REG_CTRL}, 32'd0);

    // config readback, other axes keep their values
    for (int a = 0; a < `STEP_NUM_AXES; a++)
    begin
      add_write(a, `STEP_REG_PERIOD, 32'h0100_0000 | rand_below(30000));
      add_write(a, `STEP_REG_PULSES, 32'h0200_0000 | rand_below(30000));
      add_write(a, `STEP_REG_DIR, 32'd1);
      for (int b = 0; b < `STEP_NUM_AXES; b++)
        add_cfg_reads(b);
    end

    // counted runs on every axis
    for (int a = 0; a < `STEP_NUM_AXES; a++)
    begin
      p = 2 + rand_below(8);
      n = 1 + rand_below(20);
      add_write(a, `STEP_REG_PERIOD, p);
      add_write(a, `STEP_REG_PULSES, n);
      add_write(a, `STEP_REG_DIR, (a % 2 == 0) ? 32'd0 : 32'd1);
      add_entry(OP_MARK, reg_addr(a, 4'd0), 32'd0, 32'd0);
      add_write(a, `STEP_REG_CTRL, 32'h4);
      add_entry(OP_WAIT, 8'h00, n * p - 1, 32'd0); // just before the last pulse
      add_entry(OP_EN, reg_addr(a, 4'd0), 32'd0, 32'd1);
      add_entry(OP_DIR, reg_addr(a, 4'd0), 32'd0, 32'(sh_dir[a]));
      add_entry(OP_WAIT, 8'h00, 32'd5, 32'd0);
      add_entry(OP_PULSES, reg_addr(a, 4'd0), 32'd0, n);
      add_entry(OP_EN, reg_addr(a, 4'd0), 32'd0, 32'd0);
      add_read(reg_addr(a, `STEP_REG_STATE), 32'(ST_IDLE));
      add_read(reg_addr(a, `STEP_REG_COUNT), n);
    end

    // free run on axis 0, then stop
    p = 2 + rand_below(8);
    w = 10 + rand_below(40);
    add_write(0, `STEP_REG_PERIOD, p);
    add_entry(OP_MARK, reg_addr(0, 4'd0), 32'd0, 32'd0);
    add_write(0, `STEP_REG_CTRL, 32'h2);
    add_entry(OP_WAIT, 8'h00, w, 32'd0);
    add_entry(OP_EN, reg_addr(0, 4'd0), 32'd0, 32'd1);
    add_read(reg_addr(0, `STEP_REG_STATE), 32'(ST_MOVE));
    add_write(0, `STEP_REG_CTRL, 32'h1);
    add_entry(OP_WAIT, 8'h00, 32'd3, 32'd0);
    add_read(reg_addr(0, `STEP_REG_STATE), 32'(ST_IDLE));
    add_entry(OP_EN, reg_addr(0, 4'd0), 32'd0, 32'd0);
    add_entry(OP_RD_MON, reg_addr(0, `STEP_REG_COUNT), 32'd0, 32'd0);

    // counted run cut short around half way
    p = 2 + rand_below(8);
    n = 1 + rand_below(20);
    add_write(last, `STEP_REG_PERIOD, p);
    add_write(last, `STEP_REG_PULSES, n);
    add_entry(OP_MARK, reg_addr(last, 4'd0), 32'd0, 32'd0);
    add_write(last, `STEP_REG_CTRL, 32'h4);
    add_entry(OP_WAIT, 8'h00, p * (n / 2), 32'd0);
    add_write(last, `STEP_REG_CTRL, 32'h1);
    add_entry(OP_WAIT, 8'h00, 32'd3, 32'd0);
    add_read(reg_addr(last, `STEP_REG_STATE), 32'(ST_IDLE));
    add_entry(OP_EN, reg_addr(last, 4'd0), 32'd0, 32'd0);
    add_entry(OP_RD_MON, reg_addr(last, `STEP_REG_COUNT), 32'd0, 32'd0);
    add_entry(OP_BELOW, reg_addr(last, 4'd0), 32'd0, n);

    // each kind of unmapped write sets the flag on its own and nothing else
    for (int k = 0; k < 3; k++)
    begin
      if (k > 0)
      begin
        add_entry(OP_RST, 8'h00, 32'd2, 32'd0); // only reset clears the flag
        clear_shadows();
      end
      add_read({`STEP_ERR_AXIS, `STEP_REG_CTRL}, 32'd0);
      case (k)
        0: add_write(0, 4'd3, 32'h0000_00ff);
        1: add_write(last, `STEP_REG_STATE, 32'h2); // read only
        default: add_write(`STEP_NUM_AXES, `STEP_REG_PERIOD, 32'h77);
      endcase
      add_entry(OP_WAIT, 8'h00, 32'd4, 32'd0); // flag is sticky
      add_read({`STEP_ERR_AXIS, `STEP_REG_CTRL}, 32'd1);
      for (int a = 0; a < `STEP_NUM_AXES; a++)
      begin
        add_read(reg_addr(a, `STEP_REG_STATE), 32'(ST_IDLE));
        add_cfg_reads(a);
      end
    end
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic apply_entry(input entry_t e);
    int a;
    a = int'(e.addr[7:4]);
    case (e.op)
      OP_WR:
      begin
        address   = e.addr;
        writedata = e.data;
        write     = 1'b1;
        next_cycle();
        write = 1'b0;
      end
      OP_RD, OP_RD_MON:
      begin
        address = e.addr;
        read    = 1'b1;
        next_cycle();
        read = 1'b0; // readdata settled at the edge just passed
        if (e.op == OP_RD)
          check(readdata, e.exp, $sformatf("readdata at 0x%02h", e.addr));
        else
          check(readdata, mon_cnt[a] - mark[a], $sformatf("count vs monitor, axis %0d", a));
      end
      OP_WAIT:
        repeat (e.data) next_cycle();
      OP_RST:
      begin
        rst = 1'b1;
        repeat (e.data) next_cycle();
        rst = 1'b0;
      end
      OP_MARK:
        mark[a] = mon_cnt[a];
      OP_PULSES:
        check(mon_cnt[a] - mark[a], e.exp, $sformatf("step pulses, axis %0d", a));
      OP_BELOW:
        check(32'(mon_cnt[a] - mark[a] < e.exp), 32'd1,
              $sformatf("stopped run below pulse number, axis %0d", a));
      OP_EN:
        check(32'(enable[a]), e.exp, $sformatf("enable, axis %0d", a));
      OP_DIR:
        check(32'(dir[a]), e.exp, $sformatf("dir, axis %0d", a));
      default:
        check(32'd0, 32'd1, "unknown table operation");
    endcase
  endtask

  initial
  begin : watchdog
    int unsigned limit;
    wait (table_ready);
    limit = wait_total + 20 * tbl.size() + 20;
    #(limit * 20);
    $display("Simulation failed");
    $fatal(1, "timeout, the test table did not finish within %0d cycles", limit);
  end

  initial
  begin
    rst       = 1'b1;
    address   = 8'h00;
    writedata = 32'h0;
    write     = 1'b0;
    read      = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    foreach (tbl[i])
      apply_entry(tbl[i]);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen
#(
  parameter int PERIOD = 20
)
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD / 2) clk = ~clk;
  end

endmodule

/* step_top.sv */
`include "step_defs.svh"

module step_top
  import step_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic [7:0]                address,
  input  logic [31:0]               writedata,
  input  logic                      write,
  input  logic                      read,
  output logic [31:0]               readdata,
  output logic [`STEP_NUM_AXES-1:0] step,
  output logic [`STEP_NUM_AXES-1:0] dir,
  output logic [`STEP_NUM_AXES-1:0] enable
);

  axis_cfg_t  [`STEP_NUM_AXES-1:0] cfg;
  axis_cmd_t  [`STEP_NUM_AXES-1:0] cmd;
  axis_stat_t [`STEP_NUM_AXES-1:0] stat;
  logic                            wr_err;

  step_csr step_csr_inst
  (
    .clk       (clk),
    .rst       (rst),
    .address   (address),
    .writedata (writedata),
    .write     (write),
    .cfg       (cfg),
    .cmd       (cmd),
    .wr_err    (wr_err)
  );

  for (genvar i = 0; i < `STEP_NUM_AXES; i++)
  begin : g_axis
    step_axis step_axis_inst
    (
      .clk    (clk),
      .rst    (rst),
      .cfg    (cfg[i]),
      .cmd    (cmd[i]),
      .stat   (stat[i]),
      .step   (step[i]),
      .dir    (dir[i]),
      .enable (enable[i])
    );
  end

  step_readback step_readback_inst
  (
    .clk      (clk),
    .rst      (rst),
    .address  (address),
    .read     (read),
    .write    (write),
    .cfg      (cfg),
    .stat     (stat),
    .wr_err   (wr_err),
    .readdata (readdata)
  );

endmodule

/* step_readback.sv */
`include "step_defs.svh"

module step_readback
  import step_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,
  input  logic [7:0]                      address,
  input  logic                            read,
  input  logic                            write,
  input  axis_cfg_t  [`STEP_NUM_AXES-1:0] cfg,
  input  axis_stat_t [`STEP_NUM_AXES-1:0] stat,
  input  logic                            wr_err,
  output logic [31:0]                     readdata
);

  logic [3:0] axis_sel;
  reg_off_e   off;
  axis_cfg_t  sel_cfg;
  axis_stat_t sel_stat;
  logic [31:0] rd_mux;

  assign axis_sel = address[7:4];
  assign off      = reg_off_e'(address[3:0]);

  always_comb
  begin
    sel_cfg  = '0;
    sel_stat = '0;
    for (int i = 0; i < `STEP_NUM_AXES; i++)
    begin
      if (axis_sel == 4'(i))
      begin
        sel_cfg  = cfg[i];
        sel_stat = stat[i];
      end
    end
  end

  always_comb
  begin
    rd_mux = '0; // CTRL and holes read 0
    if (axis_sel == `STEP_ERR_AXIS)
    begin
      if (off == REG_CTRL)
        rd_mux = {31'b0, wr_err};
    end
    else if (axis_sel < 4'(`STEP_NUM_AXES))
    begin
      case (off)
        REG_STATE:  rd_mux = 32'(sel_stat.state);
        REG_COUNT:  rd_mux = sel_stat.step_count;
        REG_PERIOD: rd_mux = sel_cfg.period;
        REG_PULSES: rd_mux = sel_cfg.pulse_number;
        REG_DIR:    rd_mux = {31'b0, sel_cfg.dir};
        default:    rd_mux = '0;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      readdata <= '0;
    else if (read && !write) // write wins a collision
      readdata <= rd_mux;
  end

endmodule

/* step_axis.sv */
`include "step_defs.svh"

module step_axis
  import step_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  axis_cfg_t  cfg,
  input  axis_cmd_t  cmd,
  output axis_stat_t stat,
  output logic       step,
  output logic       dir,
  output logic       enable
);

  axis_state_e            state;
  axis_state_e            next_state;
  logic [`STEP_CNT_W-1:0] timer;
  logic [`STEP_CNT_W-1:0] step_count;
  logic [`STEP_CNT_W-1:0] period_eff;
  logic                   moving;
  logic                   entry;
  logic                   done_n;
  logic                   dir_q;

  // periods of 0 and 1 run at 2
  assign period_eff = (cfg.period < `STEP_CNT_W'(2)) ? `STEP_CNT_W'(2) : cfg.period;

  assign moving = (state != ST_IDLE);
  assign entry  = (state == ST_IDLE) && (next_state != ST_IDLE);
  assign step   = (timer == period_eff); // timer rests at 0 while idle

  // last counted pulse, or nothing to do at all
  assign done_n = (cfg.pulse_number == '0) ||
                  (step && (step_count + 1'b1 >= cfg.pulse_number));

  always_comb
  begin
    case (state)
      ST_IDLE:
      begin
        if (cmd.start)
          next_state = ST_MOVE; // start beats start_n
        else if (cmd.start_n)
          next_state = ST_MOVE_N;
        else
          next_state = ST_IDLE;
      end
      ST_MOVE:
        next_state = cmd.stop ? ST_IDLE : ST_MOVE;
      ST_MOVE_N:
        next_state = (cmd.stop || done_n) ? ST_IDLE : ST_MOVE_N;
      default:
        next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= ST_IDLE;
      timer      <= '0;
      step_count <= '0;
      dir_q      <= 1'b0;
    end
    else
    begin
      state <= next_state;
      if (entry)
      begin
        timer      <= '0;
        step_count <= '0;
        dir_q      <= cfg.dir; // held for the whole run
      end
      else if (moving)
      begin
        if (step)
        begin
          timer      <= `STEP_CNT_W'(1);
          step_count <= step_count + 1'b1;
        end
        else
          timer <= timer + 1'b1;
        if (next_state == ST_IDLE)
          timer <= '0; // parked until the next run
      end
    end
  end

  // driver enable follows next state, up in the command cycle
  assign enable = (next_state != ST_IDLE);
  assign dir    = dir_q;

  assign stat.state      = state;
  assign stat.step_count = step_count;

  a_no_step_idle: assert property (@(posedge clk) disable iff (rst)
    (state == ST_IDLE) |-> !step);

  a_enable_idle: assert property (@(posedge clk) disable iff (rst)
    (state == ST_IDLE && !cmd.start && !cmd.start_n) |-> !enable);

endmodule

/* step_csr.sv */
`include "step_defs.svh"

module step_csr
  import step_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst,
  input  logic [7:0]                          address,
  input  logic [31:0]                         writedata,
  input  logic                                write,
  output axis_cfg_t [`STEP_NUM_AXES-1:0]      cfg,
  output axis_cmd_t [`STEP_NUM_AXES-1:0]      cmd,
  output logic                                wr_err
);

  logic [3:0] axis_sel;
  reg_off_e   off;
  logic       axis_ok;
  logic       off_ok;

  assign axis_sel = address[7:4];
  assign off      = reg_off_e'(address[3:0]);
  assign axis_ok  = axis_sel < 4'(`STEP_NUM_AXES);

  // only these offsets take writes
  assign off_ok = (off == REG_CTRL) || (off == REG_PERIOD) ||
                  (off == REG_PULSES) || (off == REG_DIR);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cfg    <= '0;
      cmd    <= '0;
      wr_err <= 1'b0;
    end
    else
    begin
      cmd <= '0; // pulses last one cycle

      if (write && !(axis_ok && off_ok))
        wr_err <= 1'b1; // sticky until reset

      for (int i = 0; i < `STEP_NUM_AXES; i++)
      begin
        if (write && axis_sel == 4'(i))
        begin
          case (off)
            REG_CTRL:
            begin
              cmd[i].stop    <= writedata[0];
              cmd[i].start   <= writedata[1];
              cmd[i].start_n <= writedata[2];
            end
            REG_PERIOD:
              cfg[i].period <= writedata;
            REG_PULSES:
              cfg[i].pulse_number <= writedata;
            REG_DIR:
              cfg[i].dir <= writedata[0];
            default:
            begin
            end
          endcase
        end
      end
    end
  end

  // a command bit never stays up across two cycles
  a_cmd_one_cycle: assert property (@(posedge clk) disable iff (rst)
    (cmd & $past(cmd)) == '0);

endmodule

/* step_pkg.sv */
`include "step_defs.svh"

package step_pkg;

  typedef enum logic [1:0]
  {
    ST_IDLE   = 2'd0,
    ST_MOVE   = 2'd1, // free run until stop
    ST_MOVE_N = 2'd2  // counted run
  } axis_state_e;

  typedef enum logic [3:0]
  {
    REG_CTRL   = `STEP_REG_CTRL,
    REG_STATE  = `STEP_REG_STATE,
    REG_COUNT  = `STEP_REG_COUNT,
    REG_PERIOD = `STEP_REG_PERIOD,
    REG_PULSES = `STEP_REG_PULSES,
    REG_DIR    = `STEP_REG_DIR
  } reg_off_e;

  typedef struct packed
  {
    logic [`STEP_CNT_W-1:0] period;       // clocks between step pulses
    logic [`STEP_CNT_W-1:0] pulse_number; // steps per MOVE_N run
    logic                   dir;
  } axis_cfg_t;

  // one-cycle pulses from the CTRL register
  typedef struct packed
  {
    logic start;
    logic start_n;
    logic stop;
  } axis_cmd_t;

  typedef struct packed
  {
    axis_state_e            state;
    logic [`STEP_CNT_W-1:0] step_count;
  } axis_stat_t;

endpackage

/* step_defs.svh */
`ifndef STEP_DEFS_SVH
`define STEP_DEFS_SVH

// axis count, 1 to 15 (axis field 15 is the global page)
`define STEP_NUM_AXES 4

// period, pulse number and step count width, one bus word
`define STEP_CNT_W 32

// axis field value that selects the global registers
`define STEP_ERR_AXIS 4'd15

// register offsets inside an axis page
`define STEP_REG_CTRL   4'd0
`define STEP_REG_STATE  4'd2
`define STEP_REG_COUNT  4'd4
`define STEP_REG_PERIOD 4'd5
`define STEP_REG_PULSES 4'd6
`define STEP_REG_DIR    4'd7

`endif
